// File: Makefile
# Verilator flow for the bus protocol hardening unit
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bus_hardening
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Verification failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o V$(TOP)

# The run fails on a nonzero exit status or when the log holds the fail message
sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/hardening_checker.sv
// Scoreboard that runs a reference model of the hardening unit and compares the DUT outputs mid-cycle
module hardening_checker
  import obi_bus_pkg::*;
  import alert_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  obi_ch_t [NUM_CH-1:0] i_ch,
  input  logic                 i_alert_clear,
  input  logic                 i_alert_major,
  input  err_info_t            i_err_info,
  input  cnt_t    [NUM_CH-1:0] i_outstanding,
  input  logic                 i_exp_valid,
  input  logic                 i_exp_alert,
  input  logic                 i_done,
  output int                   o_errors,
  output int                   o_checks
);
  timeunit 1ns;
  timeprecision 100ps;

  // Model state reflects the inputs sampled up to the last rising edge
  int        m_cnt [NUM_CH];
  err_code_t m_err [NUM_CH];
  logic      m_alert;
  err_info_t m_info;

  int   errors = 0;
  int   checks = 0;
  logic reported = 1'b0;

  assign o_errors = errors;
  assign o_checks = checks;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("ERROR: %s expected 0x%0h got 0x%0h at %0t ns", name, exp, got, $time);
    end
  endtask

  // Predicts what the next rising edge does with the inputs of the running cycle
  task automatic step_model();
    int   nxt;
    logic any_err;
    logic acc;
    any_err = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      any_err = any_err | (m_err[ch] != ERR_NONE);
    end
    // Alert and capture react to the codes registered at the previous edge
    if (!m_alert && any_err) begin
      m_alert = 1'b1;
      m_info  = '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        m_info.ch_mask[ch] = (m_err[ch] != ERR_NONE);
      end
      m_info.code_ch0 = m_err[0];
      m_info.code_ch1 = m_err[1];
    end else if (m_alert && i_alert_clear && !any_err) begin
      m_alert = 1'b0;
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      acc       = i_ch[ch].req & i_ch[ch].gnt;
      nxt       = m_cnt[ch] + int'(acc) - int'(i_ch[ch].rvalid);
      m_err[ch] = ERR_NONE;
      if (i_ch[ch].rvalid && (m_cnt[ch] == 0)) begin
        // An illegal response leaves only a same-cycle acceptance open
        m_err[ch] = ERR_RESP_NO_REQ;
        nxt       = int'(acc);
      end else if (nxt > int'(MAX_OUTSTANDING)) begin
        m_err[ch] = ERR_OVERFLOW;
        nxt       = int'(MAX_OUTSTANDING);
      end
      m_cnt[ch] = nxt;
    end
  endtask

  // Falling edge is half a cycle away from both the DUT update and the stimulus
  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        m_cnt[ch] = 0;
        m_err[ch] = ERR_NONE;
      end
      m_alert = 1'b0;
      m_info  = '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        compare($sformatf("o_outstanding[%0d]", ch), 32'(m_cnt[ch]), 32'(i_outstanding[ch]));
      end
      compare("o_alert_major", 32'(m_alert), 32'(i_alert_major));
      compare("o_err_info", 32'(m_info), 32'(i_err_info));
      // The table value is a second, hand-written opinion on the alert
      if (i_exp_valid) begin
        compare("o_alert_major", 32'(i_exp_alert), 32'(i_alert_major));
      end
      step_model();
    end
    if (i_done && !reported) begin
      reported = 1'b1;
      $display("Checks: %0d, errors: %0d", checks, errors);
    end
  end

endmodule

// File: dv/tb_bus_hardening.sv
// Testbench top that applies the stimulus table to the hardening unit, then random legal traffic
module tb_bus_hardening
  import obi_bus_pkg::*;
  import alert_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RAND_CYCLES = 200;
  localparam int unsigned MARGIN      = 20;
  localparam logic [31:0] SEED        = 32'h75c67e38;

  // One row is one clock cycle of stimulus plus the alert expected during it
  typedef struct packed {
    logic                 rst_n;
    logic                 clear;
    logic                 exp_alert;
    obi_ch_t [NUM_CH-1:0] ch;
  } row_t;

  logic                 clk_i;
  logic                 rst_ni;
  obi_ch_t [NUM_CH-1:0] ch;
  logic                 alert_clear;
  logic                 alert_major;
  err_info_t            err_info;
  cnt_t    [NUM_CH-1:0] outstanding;
  logic                 exp_valid;
  logic                 exp_alert;
  logic                 done;
  int                   errors;
  int                   checks;

  row_t  rows[$];
  int    row_test[$];
  string test_names[$];
  int    test_err_base = 0;
  int    soft_cnt [NUM_CH];
  int    cycle_cnt = 0;
  int    cycle_limit = 0;

  bus_hardening_top uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_ch          (ch),
    .i_alert_clear (alert_clear),
    .o_alert_major (alert_major),
    .o_err_info    (err_info),
    .o_outstanding (outstanding)
  );

  hardening_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_ch          (ch),
    .i_alert_clear (alert_clear),
    .i_alert_major (alert_major),
    .i_err_info    (err_info),
    .i_outstanding (outstanding),
    .i_exp_valid   (exp_valid),
    .i_exp_alert   (exp_alert),
    .i_done        (done),
    .o_errors      (errors),
    .o_checks      (checks)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run limit follows the table length plus the random phase
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic new_test(input string name);
    test_names.push_back(name);
  endtask

  // c0 and c1 are {req, gnt, rvalid} and ctrl is {clear, expected alert, rst_n}
  task automatic add_row(input logic [2:0] c0, input logic [2:0] c1, input logic [2:0] ctrl);
    row_t r;
    r.ch[0]     = obi_ch_t'(c0);
    r.ch[1]     = obi_ch_t'(c1);
    r.clear     = ctrl[2];
    r.exp_alert = ctrl[1];
    r.rst_n     = ctrl[0];
    rows.push_back(r);
    row_test.push_back(test_names.size() - 1);
  endtask

  task automatic build_table();
    new_test("legal_traffic");
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b110, 3'b110, 3'b001);
    // Acceptance and response together leave channel 0 at 2
    add_row(3'b111, 3'b001, 3'b001);
    add_row(3'b001, 3'b110, 3'b001);
    add_row(3'b100, 3'b111, 3'b001);
    add_row(3'b001, 3'b001, 3'b001);
    new_test("resp_no_req_data");
    add_row(3'b000, 3'b001, 3'b001);
    add_row(3'b000, 3'b000, 3'b001);
    add_row(3'b000, 3'b000, 3'b011);
    add_row(3'b000, 3'b000, 3'b011);
    new_test("sticky_and_clear");
    // A second error while raised must not touch the capture
    add_row(3'b001, 3'b000, 3'b011);
    add_row(3'b110, 3'b000, 3'b011);
    add_row(3'b000, 3'b000, 3'b111);
    add_row(3'b001, 3'b000, 3'b001);
    new_test("overflow_instr");
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b000, 3'b000, 3'b001);
    add_row(3'b000, 3'b000, 3'b011);
    add_row(3'b001, 3'b000, 3'b111);
    add_row(3'b001, 3'b000, 3'b001);
    add_row(3'b001, 3'b000, 3'b001);
    new_test("simultaneous_errors");
    add_row(3'b000, 3'b110, 3'b001);
    add_row(3'b000, 3'b110, 3'b001);
    add_row(3'b000, 3'b110, 3'b001);
    // Response without request on channel 0 and overflow on channel 1
    add_row(3'b001, 3'b110, 3'b001);
    add_row(3'b000, 3'b000, 3'b001);
    add_row(3'b000, 3'b001, 3'b111);
    add_row(3'b000, 3'b001, 3'b001);
    add_row(3'b000, 3'b001, 3'b001);
    new_test("reset_midrun");
    add_row(3'b110, 3'b110, 3'b001);
    add_row(3'b000, 3'b001, 3'b001);
    add_row(3'b000, 3'b001, 3'b001);
    add_row(3'b000, 3'b000, 3'b001);
    add_row(3'b000, 3'b000, 3'b011);
    add_row(3'b000, 3'b000, 3'b010);
    add_row(3'b000, 3'b000, 3'b000);
    add_row(3'b110, 3'b000, 3'b001);
    add_row(3'b001, 3'b000, 3'b001);
  endtask

  task automatic apply_row(input row_t r);
    rst_ni      = r.rst_n;
    alert_clear = r.clear;
    ch          = r.ch;
    exp_alert   = r.exp_alert;
    exp_valid   = r.rst_n;
  endtask

  task automatic report_test(input int t);
    $display("Test %s: %s, %0d errors", test_names[t],
             (errors == test_err_base) ? "PASS" : "FAIL", errors - test_err_base);
    test_err_base = errors;
  endtask

  // Responses need an open phase and acceptances need room, so only legal traffic is driven
  task automatic drive_random();
    logic acc;
    logic resp;
    for (int c = 0; c < NUM_CH; c++) begin
      acc  = (soft_cnt[c] < int'(MAX_OUTSTANDING)) ? 1'($urandom) : 1'b0;
      resp = (soft_cnt[c] > 0) ? 1'($urandom) : 1'b0;
      ch[c].req    = acc | 1'($urandom);
      ch[c].gnt    = acc;
      ch[c].rvalid = resp;
      soft_cnt[c]  = soft_cnt[c] + int'(acc) - int'(resp);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni      = 1'b0;
    ch          = '0;
    alert_clear = 1'b0;
    exp_valid   = 1'b0;
    exp_alert   = 1'b0;
    done        = 1'b0;
    for (int c = 0; c < NUM_CH; c++) begin
      soft_cnt[c] = 0;
    end
    build_table();
    cycle_limit = rows.size() + RAND_CYCLES + MARGIN;
    repeat (2) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk_i);
      // The previous test's last row was checked at the falling edge before this one
      if ((i > 0) && (row_test[i] != row_test[i-1])) begin
        report_test(row_test[i-1]);
      end
      #5;
      apply_row(rows[i]);
    end
    @(posedge clk_i);
    report_test(row_test[rows.size()-1]);
    new_test("random_legal");
    alert_clear = 1'b0;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      #5;
      drive_random();
      exp_valid = 1'b1;
      exp_alert = 1'b0;
      @(posedge clk_i);
    end
    report_test(test_names.size() - 1);
    #5;
    ch   = '0;
    done = 1'b1;
    @(posedge clk_i);
    if ((errors == 0) && (checks > 0)) begin
      $display("Verification passed");
    end else begin
      if (checks == 0) begin
        $display("The checker made no comparisons during the run");
      end
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hw/alert_fsm.sv
// Sticky major alert FSM that rises on any channel error and drops on a software clear pulse
module alert_fsm
  import obi_bus_pkg::*;
  import alert_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  err_code_t [NUM_CH-1:0] i_err_codes,
  input  logic                   i_alert_clear,
  output logic                   o_capture_en,
  output logic                   o_alert_major
);

  alert_state_e state_d;
  alert_state_e state_q;

  // High when at least one channel reports a violation this cycle
  logic any_err;

  // Reduce the per-channel codes to a single error condition
  always_comb begin
    any_err = 1'b0;
    for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
      if (i_err_codes[ch] != ERR_NONE) begin
        any_err = 1'b1;
      end
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ALERT_ARMED: begin
        // Any violation raises the alert at the next edge
        if (any_err) begin
          state_d = ALERT_RAISED;
        end
      end
      ALERT_RAISED: begin
        // Further errors are ignored here
        // A clear only takes effect when no new error arrives at the same edge
        if (i_alert_clear && !any_err) begin
          state_d = ALERT_ARMED;
        end
      end
      default: begin
        state_d = ALERT_RAISED;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ALERT_ARMED;
    end else begin
      state_q <= state_d;
    end
  end

  // Snapshot strobe lines up with the edge at which the alert rises
  // Only the first event of an alert episode is captured
  assign o_capture_en  = (state_q == ALERT_ARMED) && any_err;

  // Major alert stays up for the whole raised state
  assign o_alert_major = (state_q == ALERT_RAISED);

endmodule

// File: hw/alert_pkg.sv
// Error reporting definitions for the hardening unit, shared by the alert FSM and capture logic
package alert_pkg;

  // The capture record needs the channel mask type
  import obi_bus_pkg::*;

  // Cause of a protocol violation on one channel
  typedef logic [1:0] err_code_t;

  // No violation in this cycle
  localparam err_code_t ERR_NONE = 2'd0;
  // A response arrived while nothing was outstanding
  localparam err_code_t ERR_RESP_NO_REQ = 2'd1;
  // An acceptance would push the count past its limit
  localparam err_code_t ERR_OVERFLOW = 2'd2;

  // The alert is sticky, so two states are enough
  typedef enum logic [0:0] {
    ALERT_ARMED = 1'b0,
    ALERT_RAISED = 1'b1
  } alert_state_e;

  // Snapshot of the event that raised the alert
  typedef struct packed {
    // Channels whose code was nonzero
    ch_mask_t ch_mask;
    // Cause on the instruction channel
    err_code_t code_ch0;
    // Cause on the data channel
    err_code_t code_ch1;
  } err_info_t;

endpackage

// File: hw/bus_hardening_top.sv
// Top level of the bus protocol hardening unit, placed beside the instruction and data OBI ports
module bus_hardening_top
  import obi_bus_pkg::*;
  import alert_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  obi_ch_t [NUM_CH-1:0] i_ch,
  input  logic                 i_alert_clear,
  output logic                 o_alert_major,
  output err_info_t            o_err_info,
  output cnt_t    [NUM_CH-1:0] o_outstanding
);

  // One-cycle violation causes from the counters
  err_code_t [NUM_CH-1:0] err_codes;

  // Strobe from the FSM that freezes the first failing event
  logic capture_en;

  // One counter per channel
  // Channel 0 watches instruction fetch and channel 1 the data port
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    outstanding_counter u_counter (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .i_ch       (i_ch[ch]),
      .o_cnt      (o_outstanding[ch]),
      .o_err_code (err_codes[ch])
    );
  end

  // Sticky major alert
  alert_fsm u_alert_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_err_codes   (err_codes),
    .i_alert_clear (i_alert_clear),
    .o_capture_en  (capture_en),
    .o_alert_major (o_alert_major)
  );

  // Record of which channels failed and why
  error_capture u_error_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_capture_en (capture_en),
    .i_err_codes  (err_codes),
    .o_err_info   (o_err_info)
  );

endmodule

// File: hw/error_capture.sv
// Capture register that records the failing channels and their error codes when the alert rises
module error_capture
  import obi_bus_pkg::*;
  import alert_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i_capture_en,
  input  err_code_t [NUM_CH-1:0] i_err_codes,
  output err_info_t              o_err_info
);

  // Record assembled from the current codes
  err_info_t info_d;
  // Record of the event that raised the alert
  err_info_t info_q;

  // Build the mask from the channels that reported a violation
  always_comb begin
    info_d = '0;
    for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
      info_d.ch_mask[ch] = (i_err_codes[ch] != ERR_NONE);
    end
    // Causes are kept per channel so simultaneous errors stay distinguishable
    info_d.code_ch0 = i_err_codes[0];
    info_d.code_ch1 = i_err_codes[1];
  end

  // Load only on the strobe from the FSM
  // Later errors during the alert would otherwise hide the first one
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      info_q <= '0;
    end else if (i_capture_en) begin
      info_q <= info_d;
    end
  end

  assign o_err_info = info_q;

endmodule

// File: hw/obi_bus_pkg.sv
// Shared bus definitions for the protocol hardening unit, imported by every RTL block
package obi_bus_pkg;

  // Number of monitored channels
  // Index 0 is the instruction fetch channel and index 1 the data load/store channel
  localparam int unsigned NUM_CH = 2;

  // Most address phases that may wait for a response on one channel
  localparam int unsigned MAX_OUTSTANDING = 3;

  // Counter width, just wide enough to hold MAX_OUTSTANDING
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // Number of address phases accepted but not yet answered
  typedef logic [CNT_W-1:0] cnt_t;

  // One bit per monitored channel
  typedef logic [NUM_CH-1:0] ch_mask_t;

  // Strobes of one OBI-style channel as seen by the monitor
  // There is no ready/valid pairing on the response side
  typedef struct packed {
    // Master asks for an address phase
    logic req;
    // Slave accepts the address phase in the same cycle
    logic gnt;
    // A response phase transfer
    logic rvalid;
  } obi_ch_t;

endpackage

// File: hw/outstanding_counter.sv
// Per-channel outstanding address phase counter that flags response-without-request and overflow
module outstanding_counter
  import obi_bus_pkg::*;
  import alert_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  obi_ch_t   i_ch,
  output cnt_t      o_cnt,
  output err_code_t o_err_code
);

  // An address phase counts once both req and gnt are high
  logic accept;
  // Every rvalid cycle is one response
  logic resp;

  cnt_t      cnt_d;
  cnt_t      cnt_q;
  err_code_t err_d;
  err_code_t err_q;

  assign accept = i_ch.req & i_ch.gnt;
  assign resp   = i_ch.rvalid;

  // Next count and violation cause
  // The count saturates at both ends instead of wrapping
  always_comb begin
    cnt_d = cnt_q;
    err_d = ERR_NONE;
    if (resp && (cnt_q == '0)) begin
      // Nothing to answer, so the response is illegal
      // An acceptance in the same cycle still opens one phase
      err_d = ERR_RESP_NO_REQ;
      cnt_d = accept ? cnt_t'(1) : '0;
    end else if (accept && !resp && (cnt_q == cnt_t'(MAX_OUTSTANDING))) begin
      // One phase too many, the count holds at the limit
      err_d = ERR_OVERFLOW;
    end else if (accept && !resp) begin
      cnt_d = cnt_q + cnt_t'(1);
    end else if (resp && !accept) begin
      cnt_d = cnt_q - cnt_t'(1);
    end
    // Acceptance and response together cancel out
  end

  // The cause is held for exactly one cycle after the offending edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      err_q <= ERR_NONE;
    end else begin
      cnt_q <= cnt_d;
      err_q <= err_d;
    end
  end

  assign o_cnt      = cnt_q;
  assign o_err_code = err_q;

endmodule

// File: list.f
hw/obi_bus_pkg.sv
hw/alert_pkg.sv
hw/outstanding_counter.sv
hw/alert_fsm.sv
hw/error_capture.sv
hw/bus_hardening_top.sv
dv/hardening_checker.sv
dv/tb_bus_hardening.sv
